// ==== filelist.f ====
+incdir+.
seq_pkg.sv
reg_decode.sv
rail_sequencer.sv
status_readback.sv
power_seq_top.sv
tb_clock_gen.sv
power_seq_tb.sv

// ==== power_seq_tb.sv ====
//--------------------------------------------------------------------
// Testbench of the power-rail sequencer. Models the rail power-good
// responses, drives the host register port and checks sequencing,
// fault handling and readback with assertions.
//--------------------------------------------------------------------
`include "seq_cfg.svh"

module power_seq_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// Sum of the test lengths is well under 1500 cycles
	localparam int max_cycles = 6000;
	localparam int up_limit = `SEQ_RAIL_COUNT * (20 + `SEQ_SETTLE_CYCLES + 8);
	localparam int down_limit = 60;
	localparam logic [7:0] all_rails = 8'((1 << `SEQ_RAIL_COUNT) - 1);

	logic clk_in;
	logic rst_n;
	logic sysen;
	seq_pkg::rail_vec_t rail_pg;
	seq_pkg::rail_vec_t rail_en;
	logic sysgood;
	logic req_valid;
	logic req_write;
	logic [7:0] req_addr;
	logic [7:0] req_wdata;
	logic req_ready;
	logic resp_valid;
	logic [7:0] resp_rdata;
	logic resp_ready;

	int seed = 55;
	int mismatches = 0;
	int failures = 0;
	int cycles = 0;
	int req_idx = 0;
	int resp_idx = 0;
	logic resp_fire = 1'b0;
	logic down_check = 1'b0;
	seq_pkg::rail_vec_t pg_fault = '0;
	logic [7:0] exp_data [0:63];
	string exp_name [0:63];

	tb_clock_gen clock_i (
		.clk_in(clk_in),
		.rst_n(rst_n)
	);

	power_seq_top dut_i (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.sysen(sysen),
		.rail_pg(rail_pg),
		.rail_en(rail_en),
		.sysgood(sysgood),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_ready(resp_ready)
	);

	// Rail model: power-good follows its enable after a delay
	initial begin
		seq_pkg::rail_vec_t en_last;
		int pg_delay [`SEQ_RAIL_COUNT];
		en_last = '0;
		foreach (pg_delay[i]) pg_delay[i] = 0;
		forever begin
			@(posedge clk_in);
			#2;
			for (int i = 0; i < `SEQ_RAIL_COUNT; i++) begin
				if (rail_en[i] && !en_last[i]) begin
					pg_delay[i] = 3 + {$random(seed)} % 18;
				end else if (!rail_en[i] && en_last[i]) begin
					pg_delay[i] = 3;
				end
				if (pg_fault[i]) begin
					rail_pg[i] = 1'b0;
				end else if (rail_pg[i] != rail_en[i]) begin
					if (pg_delay[i] <= 1) begin
						rail_pg[i] = rail_en[i];
					end else begin
						pg_delay[i]--;
					end
				end
			end
			en_last = rail_en;
		end
	end

	// Response bookkeeping moves on the falling edge, away from the checks
	always @(negedge clk_in) begin
		if (resp_fire) begin
			resp_idx++;
		end
		resp_fire = resp_valid && resp_ready;
	end

	always @(posedge clk_in) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("tests failed");
			$finish;
		end
	end

	assert property (@(posedge clk_in) disable iff (!rst_n)
		resp_valid && resp_ready |-> resp_rdata == exp_data[resp_idx])
	else begin
		mismatches++;
		$display("mismatch %s: expected %02h, actual %02h", exp_name[resp_idx],
			exp_data[resp_idx], $sampled(resp_rdata));
	end

	assert property (@(posedge clk_in) disable iff (!rst_n) resp_valid |-> resp_idx < req_idx)
	else begin
		failures++;
		$display("a response arrived with no request outstanding");
	end

	// Stalled response keeps its slot and its data
	assert property (@(posedge clk_in) disable iff (!rst_n)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
	else begin
		failures++;
		$display("stalled response changed or vanished");
	end

	assert property (@(posedge clk_in) disable iff (!rst_n) $rose(sysgood) |-> &rail_pg)
	else begin
		failures++;
		$display("sysgood rose before every rail was good");
	end

	for (genvar k = 0; k < `SEQ_RAIL_COUNT - 1; k++) begin : g_order
		assert property (@(posedge clk_in) disable iff (!rst_n)
			$rose(rail_en[k + 1]) |-> rail_pg[k])
		else begin
			failures++;
			$display("rail %0d enabled before rail %0d was good", k + 1, k);
		end

		assert property (@(posedge clk_in) disable iff (!rst_n || !down_check)
			$fell(rail_en[k]) |-> !rail_pg[k + 1])
		else begin
			failures++;
			$display("rail %0d disabled while rail %0d was still good", k, k + 1);
		end
	end

	task automatic tick(input int n);
		repeat (n) begin
			@(posedge clk_in);
			#2;
		end
	endtask

	function automatic logic [7:0] status_byte(input logic sg, input logic se,
		input logic ef, input logic oe, input logic we);
		seq_pkg::status_word_u w;
		w.raw = 8'h00;
		w.fields.sysgood = sg;
		w.fields.sysen = se;
		w.fields.err_found = ef;
		w.fields.operation_err = oe;
		w.fields.wait_err = we;
		return w.raw;
	endfunction

	// Request acceptance is sampled on the falling edge, where req_ready is settled
	task automatic send_req(input logic write, input logic [7:0] addr,
		input logic [7:0] expect_data, input string name);
		logic took;
		exp_data[req_idx] = expect_data;
		exp_name[req_idx] = name;
		req_idx++;
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_wdata = write ? 8'h5A : 8'h00;
		took = 1'b0;
		while (!took) begin
			@(negedge clk_in);
			took = req_ready;
			@(posedge clk_in);
			#2;
		end
		req_valid = 1'b0;
	endtask

	task automatic drain();
		while (resp_idx != req_idx) begin
			tick(1);
		end
	endtask

	task automatic host_op(input logic write, input logic [7:0] addr,
		input logic [7:0] expect_data, input string name);
		send_req(write, addr, expect_data, name);
		drain();
	endtask

	task automatic wait_rails(input seq_pkg::rail_vec_t want_en, input logic want_sg,
		input int limit, input string what);
		int n;
		n = 0;
		while ((rail_en !== want_en || sysgood !== want_sg) && n < limit) begin
			tick(1);
			n++;
		end
		assert (rail_en === want_en && sysgood === want_sg) else begin
			failures++;
			$display("%s did not happen within %0d cycles", what, limit);
		end
	endtask

	task automatic set_fault(input int rail, input logic on);
		@(negedge clk_in);
		pg_fault[rail] = on;
		@(posedge clk_in);
		#2;
	endtask

	initial begin
		sysen = 1'b0;
		rail_pg = '0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = 8'h00;
		req_wdata = 8'h00;
		resp_ready = 1'b1;
		@(posedge rst_n);
		tick(2);

		// Power-up in order
		sysen = 1'b1;
		wait_rails('1, 1'b1, up_limit, "power-up to sysgood");
		host_op(1'b0, `SEQ_ADDR_STATUS, status_byte(1, 1, 0, 0, 0), "status after power-up");
		host_op(1'b0, `SEQ_ADDR_EN_STAT, all_rails, "enables after power-up");
		host_op(1'b0, `SEQ_ADDR_PG_STAT, all_rails, "power-good after power-up");

		// Power-down in reverse order
		down_check = 1'b1;
		sysen = 1'b0;
		wait_rails('0, 1'b0, down_limit, "power-down");
		tick(6);
		down_check = 1'b0;

		// Rail 3 never reports good
		set_fault(3, 1'b1);
		sysen = 1'b1;
		wait_rails(seq_pkg::rail_vec_t'(4'hF), 1'b0, up_limit, "enable of rail 3");
		wait_rails('0, 1'b0, `SEQ_PG_TIMEOUT_CYCLES + 10, "shutdown on wait timeout");
		host_op(1'b0, `SEQ_ADDR_STATUS, status_byte(0, 1, 1, 0, 1), "status after timeout");
		host_op(1'b0, `SEQ_ADDR_FAIL_STAT, 8'(1 << 3), "fail detail after timeout");
		sysen = 1'b0;
		tick(6);
		set_fault(3, 1'b0);
		tick(4);

		// Rail 2 drops out after a full power-up
		sysen = 1'b1;
		wait_rails('1, 1'b1, up_limit, "power-up before rail drop");
		set_fault(2, 1'b1);
		wait_rails('0, 1'b0, 8, "shutdown on rail drop");
		host_op(1'b0, `SEQ_ADDR_STATUS, status_byte(0, 1, 1, 1, 0), "status after rail drop");
		host_op(1'b0, `SEQ_ADDR_FAIL_STAT, 8'(1 << 2), "fail detail after rail drop");
		set_fault(2, 1'b0);
		host_op(1'b1, `SEQ_ADDR_CLR_ERR, 8'h00, "clear write");
		host_op(1'b0, `SEQ_ADDR_STATUS, status_byte(0, 1, 0, 0, 0), "status after clear");
		sysen = 1'b0;
		wait_rails('0, 1'b0, down_limit, "power-down after clear");
		tick(6);

		// Identification, unmapped space and write response
		host_op(1'b0, `SEQ_ADDR_VERSION, `SEQ_FPGA_VERSION, "version");
		host_op(1'b0, `SEQ_ADDR_VENDOR_ID, `SEQ_VENDOR_ID0, "vendor id 0");
		host_op(1'b0, `SEQ_ADDR_VENDOR_ID + 8'd1, `SEQ_VENDOR_ID1, "vendor id 1");
		host_op(1'b0, `SEQ_ADDR_VENDOR_ID + 8'd2, `SEQ_VENDOR_ID2, "vendor id 2");
		host_op(1'b0, `SEQ_ADDR_VENDOR_ID + 8'd3, `SEQ_VENDOR_ID3, "vendor id 3");
		host_op(1'b0, 8'h05, 8'h00, "unmapped read");
		host_op(1'b1, 8'h10, 8'h00, "unmapped write");

		// Two reads queue up behind a stalled host
		resp_ready = 1'b0;
		send_req(1'b0, `SEQ_ADDR_VERSION, `SEQ_FPGA_VERSION, "stalled version");
		send_req(1'b0, `SEQ_ADDR_VENDOR_ID + 8'd3, `SEQ_VENDOR_ID3, "stalled vendor id 3");
		tick(9);
		assert (!req_ready) else begin
			failures++;
			$display("request port stayed open with both stages full");
		end
		resp_ready = 1'b1;
		drain();
		tick(4);

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== power_seq_top.sv ====
//--------------------------------------------------------------------
// Top level of the power-rail sequencer. Joins the register decode,
// the rail sequencing core and the readback stage.
//--------------------------------------------------------------------

module power_seq_top (
	input logic clk_in,
	input logic rst_n,
	input logic sysen,
	input seq_pkg::rail_vec_t rail_pg,
	output seq_pkg::rail_vec_t rail_en,
	output logic sysgood,
	input logic req_valid,
	input logic req_write,
	input logic [7:0] req_addr,
	input logic [7:0] req_wdata,
	output logic req_ready,
	output logic resp_valid,
	output logic [7:0] resp_rdata,
	input logic resp_ready
);

	logic dec_valid;
	logic dec_ready;
	seq_pkg::reg_op_t dec_op;
	logic [7:0] dec_addr;
	logic clear_req;
	seq_pkg::status_word_u status;
	seq_pkg::rail_vec_t en_stat;
	seq_pkg::rail_vec_t pg_stat;
	seq_pkg::rail_vec_t fail_detail;

	reg_decode decode_i (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_addr(dec_addr),
		.dec_ready(dec_ready),
		.clear_req(clear_req)
	);

	rail_sequencer sequencer_i (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.sysen(sysen),
		.rail_pg(rail_pg),
		.clear_req(clear_req),
		.rail_en(rail_en),
		.sysgood(sysgood),
		.status(status),
		.en_stat(en_stat),
		.pg_stat(pg_stat),
		.fail_detail(fail_detail)
	);

	status_readback readback_i (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_addr(dec_addr),
		.dec_ready(dec_ready),
		.status(status),
		.en_stat(en_stat),
		.pg_stat(pg_stat),
		.fail_detail(fail_detail),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_ready(resp_ready)
	);

endmodule

// ==== rail_sequencer.sv ====
//--------------------------------------------------------------------
// Rail sequencing core. Brings rails up in order on sysen, takes them
// down in reverse order, and latches wait and operation errors that
// force every enable low until cleared by the host or by sysen.
//--------------------------------------------------------------------
`include "seq_cfg.svh"

module rail_sequencer (
	input logic clk_in,
	input logic rst_n,
	input logic sysen,
	input seq_pkg::rail_vec_t rail_pg,
	input logic clear_req,
	output seq_pkg::rail_vec_t rail_en,
	output logic sysgood,
	output seq_pkg::status_word_u status,
	output seq_pkg::rail_vec_t en_stat,
	output seq_pkg::rail_vec_t pg_stat,
	output seq_pkg::rail_vec_t fail_detail
);

	localparam int settle_w = $clog2(`SEQ_SETTLE_CYCLES + 1);
	localparam int wait_w = $clog2(`SEQ_PG_TIMEOUT_CYCLES + 1);

	logic sysen_s1;
	logic sysen_s2;
	logic sysen_d;
	seq_pkg::rail_vec_t pg_s1;
	seq_pkg::rail_vec_t pg_s2;
	seq_pkg::rail_vec_t settled;
	seq_pkg::rail_vec_t settle_pending;
	seq_pkg::rail_vec_t settle_lowest;
	seq_pkg::rail_vec_t en_next;
	logic [settle_w-1:0] settle_cnt;
	logic [wait_w-1:0] wait_cnt;
	logic wait_err;
	logic operation_err;
	logic err_found;
	logic err_any;
	logic clear_err;
	logic sysen_fall;

	// Two-flop synchronizers, sysen_d only feeds the edge detector
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			sysen_s1 <= 1'b0;
			sysen_s2 <= 1'b0;
			sysen_d <= 1'b0;
			pg_s1 <= '0;
			pg_s2 <= '0;
		end else begin
			sysen_s1 <= sysen;
			sysen_s2 <= sysen_s1;
			sysen_d <= sysen_s2;
			pg_s1 <= rail_pg;
			pg_s2 <= pg_s1;
		end
	end

	assign sysen_fall = sysen_d && !sysen_s2;
	assign clear_err = clear_req || sysen_fall;
	assign err_any = wait_err || operation_err || err_found;

	// Rails that are up but not yet settled; the counter serves the lowest one
	assign settle_pending = pg_s2 & rail_en & ~settled;
	assign settle_lowest = settle_pending & (~settle_pending + 1'b1);

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			settled <= '0;
			settle_cnt <= '0;
		end else if (!sysen_s2 || err_any) begin
			settled <= '0;
			settle_cnt <= '0;
		end else if (|settle_pending) begin
			if (settle_cnt == settle_w'(`SEQ_SETTLE_CYCLES - 1)) begin
				settled <= settled | settle_lowest;
				settle_cnt <= '0;
			end else begin
				settle_cnt <= settle_cnt + 1'b1;
			end
		end else begin
			settle_cnt <= '0;
		end
	end

	// One rail waits for power-good at a time during bring-up
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (!sysen_s2 || err_any || !(|(rail_en & ~pg_s2))) begin
			wait_cnt <= '0;
		end else if (wait_cnt != wait_w'(`SEQ_PG_TIMEOUT_CYCLES)) begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// Error flags and fail detail, captured as the error first shows up
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			wait_err <= 1'b0;
			operation_err <= 1'b0;
			err_found <= 1'b0;
			fail_detail <= '0;
		end else if (clear_err) begin
			wait_err <= 1'b0;
			operation_err <= 1'b0;
			err_found <= 1'b0;
			fail_detail <= '0;
		end else begin
			if (wait_cnt == wait_w'(`SEQ_PG_TIMEOUT_CYCLES)) begin
				wait_err <= 1'b1;
			end
			if (|(settled & ~pg_s2)) begin
				operation_err <= 1'b1;
			end
			if (wait_err || operation_err) begin
				err_found <= 1'b1;
			end
			if ((wait_err || operation_err) && !err_found) begin
				fail_detail <= rail_en ^ pg_s2;
			end
		end
	end

	// Up: previous rail settled. Down: held while the next rail is still good
	assign en_next = (({settled[`SEQ_RAIL_COUNT-2:0], 1'b1} & {`SEQ_RAIL_COUNT{sysen_s2}})
		| {1'b0, pg_s2[`SEQ_RAIL_COUNT-1:1]}) & {`SEQ_RAIL_COUNT{!err_found}};

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			rail_en <= '0;
			sysgood <= 1'b0;
		end else begin
			rail_en <= en_next;
			sysgood <= settled[`SEQ_RAIL_COUNT-1];
		end
	end

	always_comb begin
		status.raw = 8'h00;
		status.fields.sysgood = sysgood;
		status.fields.sysen = sysen_s2;
		status.fields.err_found = err_found;
		status.fields.operation_err = operation_err;
		status.fields.wait_err = wait_err;
	end

	assign en_stat = rail_en;
	assign pg_stat = pg_s2;

endmodule

// ==== reg_decode.sv ====
//--------------------------------------------------------------------
// Decode stage of the host register port. Takes one request at a time
// into a register slot, classifies it and pulses clear_req for a
// write to the clear-error address.
//--------------------------------------------------------------------
`include "seq_cfg.svh"

module reg_decode (
	input logic clk_in,
	input logic rst_n,
	input logic req_valid,
	input logic req_write,
	input logic [7:0] req_addr,
	input logic [7:0] req_wdata,
	output logic req_ready,
	output logic dec_valid,
	output seq_pkg::reg_op_t dec_op,
	output logic [7:0] dec_addr,
	input logic dec_ready,
	output logic clear_req
);

	logic accept;
	logic clear_hit;

	// Slot frees up when empty or when the result stage takes the word
	assign req_ready = !dec_valid || dec_ready;
	assign accept = req_valid && req_ready;

	// Write data carries no meaning, no register here is writable
	assign clear_hit = req_write && (req_addr == `SEQ_ADDR_CLR_ERR);

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			clear_req <= 1'b0;
		end else begin
			clear_req <= accept && clear_hit;
			if (accept) begin
				dec_valid <= 1'b1;
			end else if (dec_ready) begin
				dec_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (accept) begin
			dec_addr <= req_addr;
			if (!req_write) begin
				dec_op <= seq_pkg::op_read;
			end else if (clear_hit) begin
				dec_op <= seq_pkg::op_clear_err;
			end else begin
				dec_op <= seq_pkg::op_write_other;
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the power sequencer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module power_seq_tb \
	-f filelist.f \
	-o power_seq_sim

./obj_dir/power_seq_sim | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi

echo "simulation finished without failures"

// ==== seq_cfg.svh ====
//--------------------------------------------------------------------
// Build constants for the power-rail sequencer: rail count, delays,
// host register map and read-only ID values. Include this header in
// any file that uses one of the macros.
//--------------------------------------------------------------------
`ifndef SEQ_CFG_SVH
`define SEQ_CFG_SVH

// Number of sequenced rails
`define SEQ_RAIL_COUNT 6

// Power-good must hold this long before the next rail is enabled
// Kept short for simulation, hardware wants roughly 15 ms of clocks
`define SEQ_SETTLE_CYCLES 16

// Longest wait from a rail enable to its power-good
`define SEQ_PG_TIMEOUT_CYCLES 200

// Host register map, one byte per address
`define SEQ_ADDR_VERSION 8'h00
`define SEQ_ADDR_CLR_ERR 8'h03
`define SEQ_ADDR_STATUS 8'h07
`define SEQ_ADDR_EN_STAT 8'h08
`define SEQ_ADDR_PG_STAT 8'h0A
`define SEQ_ADDR_VENDOR_ID 8'h0C
`define SEQ_ADDR_FAIL_STAT 8'h18

// Read-only identification, vendor ID spells "RCS "
`define SEQ_FPGA_VERSION 8'h08
`define SEQ_VENDOR_ID0 8'h52
`define SEQ_VENDOR_ID1 8'h43
`define SEQ_VENDOR_ID2 8'h53
`define SEQ_VENDOR_ID3 8'h20

`endif

// ==== seq_pkg.sv ====
//--------------------------------------------------------------------
// Shared types of the power-rail sequencer: the per-rail vector, the
// decoded host operation and the status register byte.
//--------------------------------------------------------------------
`include "seq_cfg.svh"

package seq_pkg;

	// One bit per rail, rail 0 comes up first
	typedef logic [`SEQ_RAIL_COUNT-1:0] rail_vec_t;

	// Host operation after address decode
	typedef enum logic [1:0] {
		op_read = 2'd0,
		op_clear_err = 2'd1,
		op_write_other = 2'd2
	} reg_op_t;

	// Status register fields, bit 0 is sysgood
	typedef struct packed {
		logic [2:0] reserved;
		logic wait_err;
		logic operation_err;
		logic err_found;
		logic sysen;
		logic sysgood;
	} status_fields_t;

	// Same byte seen as named fields or as the raw register value
	typedef union packed {
		logic [7:0] raw;
		status_fields_t fields;
	} status_word_u;

endpackage

// ==== status_readback.sv ====
//--------------------------------------------------------------------
// Result stage of the host register port. Samples read data from the
// live sequencer state into a response slot and holds it while the
// host stalls.
//--------------------------------------------------------------------
`include "seq_cfg.svh"

module status_readback (
	input logic clk_in,
	input logic rst_n,
	input logic dec_valid,
	input seq_pkg::reg_op_t dec_op,
	input logic [7:0] dec_addr,
	output logic dec_ready,
	input seq_pkg::status_word_u status,
	input seq_pkg::rail_vec_t en_stat,
	input seq_pkg::rail_vec_t pg_stat,
	input seq_pkg::rail_vec_t fail_detail,
	output logic resp_valid,
	output logic [7:0] resp_rdata,
	input logic resp_ready
);

	logic load;
	logic [7:0] rd_data;

	assign dec_ready = !resp_valid || resp_ready;
	assign load = dec_valid && dec_ready;

	// Writes and unmapped reads answer zero
	always_comb begin
		rd_data = 8'h00;
		if (dec_op == seq_pkg::op_read) begin
			case (dec_addr)
				`SEQ_ADDR_VERSION: rd_data = `SEQ_FPGA_VERSION;
				`SEQ_ADDR_STATUS: rd_data = status.raw;
				`SEQ_ADDR_EN_STAT: rd_data = 8'(en_stat);
				`SEQ_ADDR_PG_STAT: rd_data = 8'(pg_stat);
				`SEQ_ADDR_FAIL_STAT: rd_data = 8'(fail_detail);
				`SEQ_ADDR_VENDOR_ID: rd_data = `SEQ_VENDOR_ID0;
				`SEQ_ADDR_VENDOR_ID + 8'd1: rd_data = `SEQ_VENDOR_ID1;
				`SEQ_ADDR_VENDOR_ID + 8'd2: rd_data = `SEQ_VENDOR_ID2;
				`SEQ_ADDR_VENDOR_ID + 8'd3: rd_data = `SEQ_VENDOR_ID3;
				default: rd_data = 8'h00;
			endcase
		end
	end

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
		end else if (load) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0;
		end
	end

	// Data only moves when a new word enters the slot
	always_ff @(posedge clk_in) begin
		if (load) begin
			resp_rdata <= rd_data;
		end
	end

endmodule

// ==== tb_clock_gen.sv ====
//--------------------------------------------------------------------
// Testbench clock and reset for the power-rail sequencer. Makes a
// 40 ns clock and holds rst_n low for the first 8 cycles.
//--------------------------------------------------------------------

module tb_clock_gen (
	output logic clk_in,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 8;

	// Half period of 20 ns
	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;
	end

	// Release lines up with the stimulus offset after the edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk_in);
		#2;
		rst_n = 1'b1;
	end

endmodule
